// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = obj_tb
FLIST = objsprite.f

SRCS = $(shell cat $(FLIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// File: design/obj_dma.sv
// object table dma
`timescale 1ns/1ns
`default_nettype none

module obj_dma (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       trig,
    input  logic                       cfg_dma_en,
    input  logic                       vs,
    output logic [obj_pkg::EXT_AW-1:0] ext_addr,
    input  logic [15:0]                ext_data,
    output logic                       dma_bsy,
    obj_table_if.src                   tbl
);
    import obj_pkg::*;

    logic              pending;
    logic              vs_l;
    logic              run;   // address phase
    logic              wr_vld; // data phase, one cycle behind run
    logic              start;
    logic [EXT_AW-1:0] addr_d;

    assign start   = vs & ~vs_l & pending & ~dma_bsy;
    assign dma_bsy = run | wr_vld;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            vs_l     <= 1'b0;
            run      <= 1'b0;
            wr_vld   <= 1'b0;
            ext_addr <= '0;
        end else begin
            vs_l   <= vs;
            wr_vld <= run;
            if (trig && cfg_dma_en) begin
                pending <= 1'b1;
            end
            if (start) begin
                pending  <= 1'b0;
                run      <= 1'b1;
                ext_addr <= '0;
            end else if (run) begin
                ext_addr <= ext_addr + 1'b1;
                if (ext_addr == EXT_AW'(DMA_WORDS - 1)) begin
                    run <= 1'b0;
                end
            end
        end
    end

    // address of the word now on ext_data
    always_ff @(posedge clk) begin
        addr_d <= ext_addr;
    end

    // word k goes to table address k/2, bank picked by k[0]
    assign tbl.wr_addr = addr_d[EXT_AW-1:1];
    assign tbl.wr_data = ext_data;
    assign tbl.we_even = wr_vld & ~addr_d[0];
    assign tbl.we_odd  = wr_vld & addr_d[0];

endmodule

`default_nettype wire

// File: design/obj_mmr.sv
// sprite cpu registers
`timescale 1ns/1ns
`default_nettype none

module obj_mmr (
    input  logic        rst,
    input  logic        clk,
    input  logic        cs,
    input  logic        cpu_we,
    input  logic [2:0]  cpu_addr,
    input  logic [15:0] cpu_dout,
    output logic [9:0]  xoff,
    output logic [9:0]  yoff,
    output logic [7:0]  cfg,
    output logic        trig
);
    import obj_pkg::*;

    logic wr_en;

    assign wr_en = cs & cpu_we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xoff <= '0;
            yoff <= '0;
            cfg  <= '0;
            trig <= 1'b0;
        end else begin
            trig <= 1'b0; // single cycle strobe
            if (wr_en) begin
                case (cpu_addr)
                    REG_XOFF: xoff <= cpu_dout[9:0];
                    REG_YOFF: yoff <= cpu_dout[9:0];
                    REG_CFG:  cfg  <= cpu_dout[7:0];
                    REG_TRIG: trig <= 1'b1; // data ignored
                    default: begin
                        // unmapped, write dropped
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/obj_pkg.sv
// sprite scanner shared definitions
`default_nettype none

package obj_pkg;

    // object table geometry
    localparam int OBJ_COUNT = 32;
    localparam int OBJ_AW    = 5;
    localparam int TBL_AW    = 7;   // object index plus 2-bit word index
    localparam int DMA_WORDS = 256; // 8 words per object
    localparam int EXT_AW    = 8;

    // cpu register map
    localparam logic [2:0] REG_XOFF = 3'd0;
    localparam logic [2:0] REG_YOFF = 3'd1;
    localparam logic [2:0] REG_CFG  = 3'd2;
    localparam logic [2:0] REG_TRIG = 3'd3;

    // lines on which a scan may start
    localparam logic [8:0] LINE_FIRST = 9'd16;
    localparam logic [8:0] LINE_LAST  = 9'd255;

    // configuration byte fields
    localparam int CFG_HFLIP  = 0;
    localparam int CFG_VFLIP  = 1;
    localparam int CFG_DMA_EN = 4;

    // per-object walk, one cycle per table fetch
    typedef enum logic [2:0] {
        IDLE,
        HDR,
        POS,
        ATTR,
        ROW,
        DRAW
    } scan_state_t;

    // square objects, height and width grow together
    typedef enum logic [1:0] {
        SZ16,
        SZ32,
        SZ64,
        SZ128
    } obj_size_t;

endpackage

`default_nettype wire

// File: design/obj_scan.sv
// per-line sprite table scanner
`timescale 1ns/1ns
`default_nettype none

module obj_scan (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       hs,
    input  logic [8:0]                 vdump,
    input  logic [9:0]                 xoff,
    input  logic [9:0]                 yoff,
    input  logic                       ghflip,
    input  logic                       gvflip,
    output logic [obj_pkg::TBL_AW-1:0] rd_addr,
    input  logic [15:0]                rd_even,
    input  logic [15:0]                rd_odd,
    output logic                       dr_start,
    input  logic                       dr_busy,
    output logic [13:0]                code,
    output logic [7:0]                 attr,
    output logic                       hflip,
    output logic                       vflip,
    output logic [8:0]                 hpos,
    output logic [3:0]                 ysub
);
    import obj_pkg::*;

    scan_state_t       state;
    scan_state_t       state_nx;
    logic [OBJ_AW-1:0] obj;
    logic [OBJ_AW-1:0] obj_nx;
    logic [1:0]        word_nx;
    logic              hs_l;
    logic              restart;
    logic              last_obj;
    logic              issue;
    logic [2:0]        col;
    logic [2:0]        cmask;   // columns minus one
    logic [2:0]        col_eff;
    logic [2:0]        rowt_eff;
    logic              hf_eff;
    logic              vf_eff;
    logic [13:0]       draw_code;
    // working copy of the current object
    logic [8:0]        line;
    logic [13:0]       base;
    logic              ohf;
    logic              ovf;
    obj_size_t         size;
    logic [9:0]        x;
    logic [9:0]        y;
    logic [8:0]        row;
    logic [7:0]        attr_w;

    assign restart  = hs & ~hs_l & (vdump >= LINE_FIRST) & (vdump <= LINE_LAST);
    assign last_obj = obj == OBJ_AW'(OBJ_COUNT - 1);

    always_comb begin
        case (size)
            SZ16:    cmask = 3'd0;
            SZ32:    cmask = 3'd1;
            SZ64:    cmask = 3'd3;
            default: cmask = 3'd7;
        endcase
    end

    assign hf_eff    = ohf ^ ghflip;
    assign vf_eff    = ovf ^ gvflip;
    assign col_eff   = hf_eff ? (col ^ cmask) : col;
    assign rowt_eff  = vf_eff ? (row[6:4] & cmask) ^ cmask : row[6:4] & cmask;
    assign draw_code = base + (14'(rowt_eff) << size) + 14'(col_eff);

    always_comb begin
        state_nx = state;
        obj_nx   = obj;
        issue    = 1'b0;
        if (restart) begin
            state_nx = HDR;
            obj_nx   = '0;
        end else begin
            case (state)
                HDR: begin
                    if (rd_even[15]) begin
                        state_nx = POS;
                    end else begin
                        state_nx = last_obj ? IDLE : HDR;
                        obj_nx   = obj + 1'b1;
                    end
                end
                POS:  state_nx = ATTR;
                ATTR: state_nx = ROW;
                ROW: begin
                    if (row[8:4] <= {2'b00, cmask}) begin // row below height
                        state_nx = DRAW;
                    end else begin
                        state_nx = last_obj ? IDLE : HDR;
                        obj_nx   = obj + 1'b1;
                    end
                end
                DRAW: begin
                    // one request, then a gap cycle before the next
                    if (!dr_busy && !dr_start) begin
                        issue = 1'b1;
                        if (col == cmask) begin
                            state_nx = last_obj ? IDLE : HDR;
                            obj_nx   = obj + 1'b1;
                        end
                    end
                end
                default: state_nx = IDLE;
            endcase
        end
    end

    // fetch ahead so data lands in the state that needs it
    always_comb begin
        case (state_nx)
            HDR:     word_nx = 2'd0;
            POS:     word_nx = 2'd1;
            default: word_nx = 2'd3;
        endcase
    end
    assign rd_addr = {obj_nx, word_nx};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            obj      <= '0;
            hs_l     <= 1'b0;
            dr_start <= 1'b0;
            col      <= '0;
        end else begin
            state    <= state_nx;
            obj      <= obj_nx;
            hs_l     <= hs;
            dr_start <= issue;
            if (state == HDR) begin
                col <= '0;
            end else if (issue) begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            line <= vdump;
        end
        case (state)
            HDR: begin
                base <= rd_odd[13:0];
                ovf  <= rd_even[13];
                ohf  <= rd_even[12];
                size <= obj_size_t'(rd_even[9:8]);
            end
            POS: begin
                y <= (gvflip ? -rd_even[9:0] : rd_even[9:0]) + yoff;
                x <= (ghflip ? -rd_odd[9:0] : rd_odd[9:0]) + xoff;
            end
            ATTR: begin
                attr_w <= rd_even[7:0];
                row    <= line - y[8:0]; // wraps mod 512
            end
            default: begin
            end
        endcase
        // draw bus only moves together with dr_start
        if (issue) begin
            code  <= draw_code;
            attr  <= attr_w;
            hflip <= hf_eff;
            vflip <= vf_eff;
            hpos  <= x[8:0] + {2'b00, col, 4'b0000};
            ysub  <= vf_eff ? ~row[3:0] : row[3:0];
        end
    end

endmodule

`default_nettype wire

// File: design/obj_sprite_top.sv
// sprite line scanner top
`timescale 1ns/1ns
`default_nettype none

module obj_sprite_top (
    input  logic                       rst,
    input  logic                       clk,
    input  logic                       cs,
    input  logic                       cpu_we,
    input  logic [2:0]                 cpu_addr,
    input  logic [15:0]                cpu_dout,
    output logic [obj_pkg::EXT_AW-1:0] ext_addr,
    input  logic [15:0]                ext_data,
    output logic                       dma_bsy,
    input  logic                       hs,
    input  logic                       vs,
    input  logic [8:0]                 vdump,
    output logic                       dr_start,
    input  logic                       dr_busy,
    output logic [13:0]                code,
    output logic [7:0]                 attr,
    output logic                       hflip,
    output logic                       vflip,
    output logic [8:0]                 hpos,
    output logic [3:0]                 ysub
);
    import obj_pkg::*;

    logic [9:0]        xoff;
    logic [9:0]        yoff;
    logic [7:0]        cfg;
    logic              trig;
    logic [TBL_AW-1:0] rd_addr;
    logic [15:0]       rd_even;
    logic [15:0]       rd_odd;

    obj_table_if u_tbl_if ();

    obj_mmr u_mmr (
        .rst      (rst),
        .clk      (clk),
        .cs       (cs),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .xoff     (xoff),
        .yoff     (yoff),
        .cfg      (cfg),
        .trig     (trig)
    );

    obj_dma u_dma (
        .rst        (rst),
        .clk        (clk),
        .trig       (trig),
        .cfg_dma_en (cfg[CFG_DMA_EN]),
        .vs         (vs),
        .ext_addr   (ext_addr),
        .ext_data   (ext_data),
        .dma_bsy    (dma_bsy),
        .tbl        (u_tbl_if.src)
    );

    obj_table_ram u_even (
        .clk      (clk),
        .wr       (u_tbl_if.sink),
        .odd_bank (1'b0),
        .rd_addr  (rd_addr),
        .rd_data  (rd_even)
    );

    obj_table_ram u_odd (
        .clk      (clk),
        .wr       (u_tbl_if.sink),
        .odd_bank (1'b1),
        .rd_addr  (rd_addr),
        .rd_data  (rd_odd)
    );

    obj_scan u_scan (
        .rst      (rst),
        .clk      (clk),
        .hs       (hs),
        .vdump    (vdump),
        .xoff     (xoff),
        .yoff     (yoff),
        .ghflip   (cfg[CFG_HFLIP]),
        .gvflip   (cfg[CFG_VFLIP]),
        .rd_addr  (rd_addr),
        .rd_even  (rd_even),
        .rd_odd   (rd_odd),
        .dr_start (dr_start),
        .dr_busy  (dr_busy),
        .code     (code),
        .attr     (attr),
        .hflip    (hflip),
        .vflip    (vflip),
        .hpos     (hpos),
        .ysub     (ysub)
    );

endmodule

`default_nettype wire

// File: design/obj_table_if.sv
// object table write port
`timescale 1ns/1ns
`default_nettype none

interface obj_table_if;
    import obj_pkg::*;

    logic [TBL_AW-1:0] wr_addr;
    logic [15:0]       wr_data;
    logic              we_even; // even words of each object
    logic              we_odd;

    // dma side
    modport src (output wr_addr, wr_data, we_even, we_odd);

    // table ram side
    modport sink (input wr_addr, wr_data, we_even, we_odd);

endinterface

`default_nettype wire

// File: design/obj_table_ram.sv
// object table ram bank
`timescale 1ns/1ns
`default_nettype none

module obj_table_ram (
    input  logic                       clk,
    obj_table_if.sink                  wr,
    input  logic                       odd_bank,
    input  logic [obj_pkg::TBL_AW-1:0] rd_addr,
    output logic [15:0]                rd_data
);
    import obj_pkg::*;

    logic [15:0] mem [0:(1<<TBL_AW)-1];
    logic        we;

    // each bank answers only its own enable
    assign we = odd_bank ? wr.we_odd : wr.we_even;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr.wr_addr] <= wr.wr_data;
        end
        rd_data <= mem[rd_addr]; // one cycle read
    end

endmodule

`default_nettype wire

// File: objsprite.f
design/obj_pkg.sv
design/obj_table_if.sv
design/obj_mmr.sv
design/obj_dma.sv
design/obj_table_ram.sv
design/obj_scan.sv
design/obj_sprite_top.sv
verif/obj_sprite_assert.sv
verif/obj_tb.sv

// File: verif/obj_sprite_assert.sv
// scanner and dma protocol checks
`timescale 1ns/1ns
`default_nettype none

module obj_sprite_assert (
    input logic        clk,
    input logic        rst,
    input logic        dr_start,
    input logic        dr_busy,
    input logic [36:0] draw,
    input logic        dma_bsy
);

    int bsy_len;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bsy_len <= 0;
        end else begin
            bsy_len <= dma_bsy ? bsy_len + 1 : 0;
        end
    end

    a_start_free: assert property (@(posedge clk) disable iff (rst)
        $rose(dr_start) |-> !$past(dr_busy)) else $error("draw start while busy");
    a_hold: assert property (@(posedge clk) disable iff (rst)
        dr_busy |=> $stable(draw)) else $error("draw bus moved while busy");
    a_dma_len: assert property (@(posedge clk) disable iff (rst)
        $fell(dma_bsy) |-> bsy_len == 257) else $error("dma busy length wrong");

endmodule

bind obj_scan obj_sprite_assert u_scan_chk (
    .clk      (clk),
    .rst      (rst),
    .dr_start (dr_start),
    .dr_busy  (dr_busy),
    .draw     ({code, attr, hflip, vflip, hpos, ysub}),
    .dma_bsy  (1'b0)
);

bind obj_dma obj_sprite_assert u_dma_chk (
    .clk      (clk),
    .rst      (rst),
    .dr_start (1'b0),
    .dr_busy  (1'b0),
    .draw     (37'd0),
    .dma_bsy  (dma_bsy)
);

`default_nettype wire

// File: verif/obj_stimulus.txt
// words 0-2: xoff yoff cfg for mode 1, then 256 table words (two objects per row)
// then line count, then per line: mode (0 plain, 1 registers set), line, expected draws
0020 0100 0013
8000 0100 0020 0028 0000 0000 0011 0000  0000 0000 0020 0028 0000 0000 0000 0000
9100 0200 0028 0064 0000 0000 0022 0000  a200 0300 001e 00c8 0000 0000 0033 0000
b300 0400 0064 0008 0000 0000 0044 0000  8000 0500 012c 0010 0000 0000 0055 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000  0000 0000 0000 0000 0000 0000 0000 0000
0008
0000 0014 0000
0000 0023 0005
0000 002d 0007
0000 0040 0006
0000 0096 0008
0001 00e6 000f
0001 00c8 0008
0001 00fa 000c

// File: verif/obj_tb.sv
// sprite scanner testbench
`timescale 1ns/1ns
`default_nettype none

module obj_tb;
    import obj_pkg::*;

    localparam int TBL = 3;    // first table word in the stimulus image
    localparam int LST = 259;  // line list: count, then mode/line/draws

    typedef struct packed {
        logic [13:0] code;
        logic [7:0]  attr;
        logic        hflip;
        logic        vflip;
        logic [8:0]  hpos;
        logic [3:0]  ysub;
    } draw_t;

    logic clk, rst, cs, cpu_we, dma_bsy, hs, vs, dr_start, dr_busy, hflip, vflip;
    logic [2:0]  cpu_addr;
    logic [15:0] cpu_dout, ext_data;
    logic [7:0]  ext_addr, attr;
    logic [7:0]  ext_addr_q; // address taken on the last edge
    logic [8:0]  vdump, hpos;
    logic [13:0] code;
    logic [3:0]  ysub;

    logic [15:0] stim [0:511];
    draw_t       got[$];
    draw_t       expq[$];
    int          errors, checks, hold, n, addr_err, tmo, base_err, i, mode, cur_mode;
    logic [9:0]  xoff_m, yoff_m;
    logic        gh, gv;

    obj_sprite_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // external ram, one cycle behind the address
    always begin
        @(posedge clk);
        #1;
        ext_data   = stim[TBL + int'(ext_addr_q)];
        ext_addr_q = ext_addr;
    end

    // line drawer with random busy time
    initial begin
        dr_busy = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (dr_start) begin
                got.push_back({code, attr, hflip, vflip, hpos, ysub});
                hold = $urandom % 4;
                if (hold != 0) begin
                    dr_busy = 1'b1;
                    repeat (hold) @(posedge clk);
                    #1;
                    dr_busy = 1'b0;
                end
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAIL %s exp %h got %h", name, exp, act);
        end
    endtask

    task automatic check_state(input scan_state_t exp);
        checks++;
        if (dut0.u_scan.state !== exp) begin
            errors++;
            $display("FAIL state exp %h got %h", exp, dut0.u_scan.state);
        end
    endtask

    task automatic check_draw(input draw_t exp, input draw_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            if (exp.code !== act.code) $display("FAIL code exp %h got %h", exp.code, act.code);
            if (exp.attr !== act.attr) $display("FAIL attr exp %h got %h", exp.attr, act.attr);
            if (exp.hpos !== act.hpos) $display("FAIL hpos exp %h got %h", exp.hpos, act.hpos);
            if (exp.ysub !== act.ysub) $display("FAIL ysub exp %h got %h", exp.ysub, act.ysub);
            if ({exp.hflip, exp.vflip} !== {act.hflip, act.vflip})
                $display("FAIL flips exp %h got %h", {exp.hflip, exp.vflip},
                         {act.hflip, act.vflip});
        end
    endtask

    task automatic cpu_write(input logic [2:0] a, input logic [15:0] d);
        cs       = 1'b1;
        cpu_we   = 1'b1;
        cpu_addr = a;
        cpu_dout = d;
        tick();
        cs     = 1'b0;
        cpu_we = 1'b0;
        tick();
    endtask

    // expected requests for one line, straight from the table words
    task automatic model_line(input int ln);
        logic [15:0] w0, wy, wx;
        logic [9:0]  y, x;
        logic [8:0]  row;
        obj_size_t   sz;
        int          o, c, cols, rowt;
        draw_t       d;
        expq.delete();
        for (o = 0; o < OBJ_COUNT; o++) begin
            w0 = stim[TBL + o * 8];
            wy = stim[TBL + o * 8 + 2];
            wx = stim[TBL + o * 8 + 3];
            sz = obj_size_t'(w0[9:8]);
            cols = 1 << sz;
            y = (gv ? -wy[9:0] : wy[9:0]) + yoff_m;
            x = (gh ? -wx[9:0] : wx[9:0]) + xoff_m;
            row = 9'(ln) - y[8:0];
            if (w0[15] && int'(row) < 16 * cols) begin
                d.hflip = w0[12] ^ gh;
                d.vflip = w0[13] ^ gv;
                rowt = int'(row) >> 4;
                if (d.vflip) rowt = cols - 1 - rowt;
                d.attr = stim[TBL + o * 8 + 6][7:0];
                d.ysub = d.vflip ? 4'(15 - int'(row[3:0])) : row[3:0];
                for (c = 0; c < cols; c++) begin
                    d.code = stim[TBL + o * 8 + 1][13:0]
                           + 14'(rowt * cols + (d.hflip ? cols - 1 - c : c));
                    d.hpos = x[8:0] + 9'(16 * c);
                    expq.push_back(d);
                end
            end
        end
    endtask

    task automatic scan_line(input int ln);
        got.delete();
        vdump = 9'(ln);
        hs    = 1'b1;
        tick();
        hs  = 1'b0;
        tmo = 0;
        while (dut0.u_scan.state != IDLE || dr_busy) begin
            tick();
            tmo++;
            if (tmo > 5000) timed_out("end of line scan");
        end
        repeat (3) tick(); // let the drawer take the last request
    endtask

    task automatic report(input string name);
        $display("test %-28s %s", name, (errors == base_err) ? "ok" : "FAILED");
        base_err = errors;
    endtask

    initial begin
        {cs, cpu_we, cpu_addr, cpu_dout, hs, vs, vdump, ext_data} = '0;
        {errors, checks, base_err, xoff_m, yoff_m, gh, gv, cur_mode} = '0;
        ext_addr_q = '0;
        void'($urandom(32'hbb64_d63c));
        $readmemh("verif/obj_stimulus.txt", stim);
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        // lines outside the window start nothing
        check_count("dr_start", 0, int'(dr_start));
        check_count("dma_bsy", 0, int'(dma_bsy));
        check_state(IDLE);
        got.delete();
        for (i = 0; i < 3; i++) begin
            vdump = (i == 1) ? 9'd300 : 9'(5 + i);
            hs    = 1'b1;
            tick();
            hs = 1'b0;
            check_state(IDLE);
            repeat (40) tick();
        end
        check_count("draws after reset", 0, got.size());
        report("reset idle");

        cpu_write(REG_CFG, 16'h0010);
        cpu_write(REG_TRIG, 16'h0000);
        vs = 1'b1;
        tick();
        vs  = 1'b0;
        tmo = 0;
        while (!dma_bsy) begin
            tick();
            tmo++;
            if (tmo > 10) timed_out("dma start");
        end
        n        = 0;
        addr_err = 0;
        while (dma_bsy) begin
            if (n < DMA_WORDS && int'(ext_addr) != n) addr_err++;
            n++;
            tick();
            if (n > 400) timed_out("dma end");
        end
        check_count("dma cycles", 257, n);
        check_count("dma addr errors", 0, addr_err);
        report("dma copy");

        // trigger with enable clear leaves dma idle
        cpu_write(REG_CFG, 16'h0000);
        cpu_write(REG_TRIG, 16'h0000);
        vs = 1'b1;
        tick();
        vs = 1'b0;
        n  = 0;
        for (i = 0; i < 20; i++) begin
            if (dma_bsy) n++;
            tick();
        end
        check_count("dma busy without enable", 0, n);
        report("dma disabled");

        for (i = 0; i < int'(stim[LST]); i++) begin
            mode = int'(stim[LST + 1 + i * 3]);
            if (mode != cur_mode) begin
                cpu_write(REG_XOFF, stim[0]);
                cpu_write(REG_YOFF, stim[1]);
                cpu_write(REG_CFG, stim[2]);
                xoff_m   = stim[0][9:0];
                yoff_m   = stim[1][9:0];
                gh       = stim[2][CFG_HFLIP];
                gv       = stim[2][CFG_VFLIP];
                cur_mode = mode;
            end
            scan_line(int'(stim[LST + 2 + i * 3]));
            model_line(int'(stim[LST + 2 + i * 3]));
            check_count("model draws", int'(stim[LST + 3 + i * 3]), expq.size());
            check_count("draws", expq.size(), got.size());
            for (n = 0; n < expq.size() && n < got.size(); n++) begin
                check_draw(expq[n], got[n]);
            end
            check_state(IDLE);
            report($sformatf("line %0d mode %0d", stim[LST + 2 + i * 3], mode));
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
